// ==== logic/isa_pkg.sv ====
package isa_pkg;

	//////////////////////////////
	// datapath
	//////////////////////////////

	localparam int XLEN = 16;

	// architectural registers
	localparam int REG_COUNT = 8;
	localparam int REG_BITS = $clog2(REG_COUNT);

	// zero-extended by move-immediate
	localparam int IMM_BITS = 8;

	//////////////////////////////
	// opcodes
	//////////////////////////////

	typedef enum logic [1:0] {
		OP_ADD,
		OP_SUB,
		OP_MOVI,
		OP_MUL
	} opcode_t;

endpackage

// ==== logic/ooo_pkg.sv ====
package ooo_pkg;

	// reorder buffer, one tag per entry
	localparam int ROB_DEPTH = 8;
	localparam int TAG_BITS = $clog2(ROB_DEPTH);

	// instruction FIFO, also the initial credit count
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);

	localparam int STATION_SLOTS = 2;
	localparam int MUL_LATENCY = 3;

	typedef enum logic [1:0] {
		ROB_FREE,
		ROB_WAIT,
		ROB_DONE
	} rob_state_t;

endpackage

// ==== logic/issue_stage.sv ====
`timescale 1ns/100ps

module issue_stage (
	input logic clk,
	input logic rst,
	input logic insn_valid,
	input isa_pkg::opcode_t insn_op,
	input logic [isa_pkg::REG_BITS-1:0] insn_rd,
	input logic [isa_pkg::REG_BITS-1:0] insn_rs1,
	input logic [isa_pkg::REG_BITS-1:0] insn_rs2,
	input logic [isa_pkg::IMM_BITS-1:0] insn_imm,
	output logic credit,
	output logic [isa_pkg::REG_BITS-1:0] read_idx [2],
	input logic reg_pending [2],
	input logic [ooo_pkg::TAG_BITS-1:0] reg_tag [2],
	input logic [isa_pkg::XLEN-1:0] reg_value [2],
	input logic rob_full,
	input logic [ooo_pkg::TAG_BITS-1:0] rob_tail_tag,
	input logic rob_ready [2],
	input logic [isa_pkg::XLEN-1:0] rob_value [2],
	output logic [ooo_pkg::TAG_BITS-1:0] rob_read_tag [2],
	input logic cdb_valid,
	input logic [ooo_pkg::TAG_BITS-1:0] cdb_tag,
	input logic [isa_pkg::XLEN-1:0] cdb_data,
	input logic alu_full,
	input logic mul_full,
	output logic alu_dispatch,
	output logic mul_dispatch,
	output isa_pkg::opcode_t dispatch_op,
	output logic [ooo_pkg::TAG_BITS-1:0] dispatch_tag,
	output logic [isa_pkg::REG_BITS-1:0] dispatch_rd,
	output logic src_ready [2],
	output logic [isa_pkg::XLEN-1:0] src_value [2],
	output logic [ooo_pkg::TAG_BITS-1:0] src_tag [2]
);
	isa_pkg::opcode_t fifo_op [ooo_pkg::FIFO_DEPTH];
	logic [isa_pkg::REG_BITS-1:0] fifo_rd [ooo_pkg::FIFO_DEPTH];
	logic [isa_pkg::REG_BITS-1:0] fifo_rs [ooo_pkg::FIFO_DEPTH][2];
	logic [isa_pkg::IMM_BITS-1:0] fifo_imm [ooo_pkg::FIFO_DEPTH];
	logic [ooo_pkg::FIFO_PTR_BITS-1:0] wr_ptr;
	logic [ooo_pkg::FIFO_PTR_BITS-1:0] rd_ptr;
	logic [ooo_pkg::FIFO_PTR_BITS:0] count;
	logic head_valid;
	logic head_mul;
	logic is_movi;
	logic pop;

	//////////////////////////////
	// instruction FIFO
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (insn_valid) begin
			fifo_op[wr_ptr] <= insn_op;
			fifo_rd[wr_ptr] <= insn_rd;
			fifo_rs[wr_ptr][0] <= insn_rs1;
			fifo_rs[wr_ptr][1] <= insn_rs2;
			fifo_imm[wr_ptr] <= insn_imm;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			if (insn_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (insn_valid && !pop)
				count <= count + 1'b1;
			else if (pop && !insn_valid)
				count <= count - 1'b1;
			// one credit back per instruction leaving
			credit <= pop;
		end
	end

	//////////////////////////////
	// decode and dispatch
	//////////////////////////////

	assign head_valid = count != '0;
	assign head_mul = fifo_op[rd_ptr] == isa_pkg::OP_MUL;
	assign is_movi = fifo_op[rd_ptr] == isa_pkg::OP_MOVI;
	assign alu_dispatch = head_valid && !head_mul && !alu_full && !rob_full;
	assign mul_dispatch = head_valid && head_mul && !mul_full && !rob_full;
	assign pop = alu_dispatch || mul_dispatch;
	assign dispatch_op = fifo_op[rd_ptr];
	assign dispatch_tag = rob_tail_tag;
	assign dispatch_rd = fifo_rd[rd_ptr];

	// register first, then reorder buffer, then result bus
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			read_idx[i] = fifo_rs[rd_ptr][i];
			rob_read_tag[i] = reg_tag[i];
			src_tag[i] = reg_tag[i];
			src_ready[i] = 1'b1;
			if (is_movi)
				src_value[i] = (i == 0) ? isa_pkg::XLEN'(fifo_imm[rd_ptr]) : '0;
			else if (!reg_pending[i])
				src_value[i] = reg_value[i];
			else if (rob_ready[i])
				src_value[i] = rob_value[i];
			else if (cdb_valid && cdb_tag == reg_tag[i])
				src_value[i] = cdb_data;
			else begin
				src_ready[i] = 1'b0;
				src_value[i] = '0;
			end
		end
	end

	// source holds no credit while the FIFO is full
	assert property (@(posedge clk) disable iff (rst)
		insn_valid |-> count != ooo_pkg::FIFO_DEPTH);

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/100ps

module register_file (
	input logic clk,
	input logic rst,
	input logic [isa_pkg::REG_BITS-1:0] read_idx [2],
	output logic reg_pending [2],
	output logic [ooo_pkg::TAG_BITS-1:0] reg_tag [2],
	output logic [isa_pkg::XLEN-1:0] reg_value [2],
	input logic rename,
	input logic [isa_pkg::REG_BITS-1:0] rename_rd,
	input logic [ooo_pkg::TAG_BITS-1:0] rename_tag,
	input logic commit,
	input logic [isa_pkg::REG_BITS-1:0] commit_rd,
	input logic [ooo_pkg::TAG_BITS-1:0] commit_tag,
	input logic [isa_pkg::XLEN-1:0] commit_data
);
	logic [isa_pkg::XLEN-1:0] regs [isa_pkg::REG_COUNT];
	logic [isa_pkg::REG_COUNT-1:0] pending;
	logic [ooo_pkg::TAG_BITS-1:0] tags [isa_pkg::REG_COUNT];

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			reg_pending[i] = pending[read_idx[i]];
			reg_tag[i] = tags[read_idx[i]];
			reg_value[i] = regs[read_idx[i]];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
			for (int k = 0; k < isa_pkg::REG_COUNT; k++)
				regs[k] <= '0;
		end else begin
			if (commit) begin
				regs[commit_rd] <= commit_data;
				// a younger producer keeps the register pending
				if (tags[commit_rd] == commit_tag)
					pending[commit_rd] <= 1'b0;
			end
			// rename wins on the same register
			if (rename)
				pending[rename_rd] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rename)
			tags[rename_rd] <= rename_tag;
	end

endmodule

// ==== logic/reorder_buffer.sv ====
`timescale 1ns/100ps

module reorder_buffer (
	input logic clk,
	input logic rst,
	input logic alloc,
	input logic [isa_pkg::REG_BITS-1:0] alloc_rd,
	output logic rob_full,
	output logic [ooo_pkg::TAG_BITS-1:0] rob_tail_tag,
	input logic [ooo_pkg::TAG_BITS-1:0] rob_read_tag [2],
	output logic rob_ready [2],
	output logic [isa_pkg::XLEN-1:0] rob_value [2],
	input logic cdb_valid,
	input logic [ooo_pkg::TAG_BITS-1:0] cdb_tag,
	input logic [isa_pkg::XLEN-1:0] cdb_data,
	output logic commit_valid,
	output logic [isa_pkg::REG_BITS-1:0] commit_rd,
	output logic [ooo_pkg::TAG_BITS-1:0] commit_tag,
	output logic [isa_pkg::XLEN-1:0] commit_data
);
	ooo_pkg::rob_state_t state [ooo_pkg::ROB_DEPTH];
	logic [isa_pkg::REG_BITS-1:0] dest [ooo_pkg::ROB_DEPTH];
	logic [isa_pkg::XLEN-1:0] value [ooo_pkg::ROB_DEPTH];
	logic [ooo_pkg::TAG_BITS-1:0] head;
	logic [ooo_pkg::TAG_BITS-1:0] tail;
	logic [ooo_pkg::TAG_BITS:0] count;

	assign rob_full = count == ooo_pkg::ROB_DEPTH;
	assign rob_tail_tag = tail;

	// operand reads for issue
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			rob_ready[i] = state[rob_read_tag[i]] == ooo_pkg::ROB_DONE;
			rob_value[i] = value[rob_read_tag[i]];
		end
	end

	//////////////////////////////
	// in-order commit
	//////////////////////////////

	assign commit_valid = state[head] == ooo_pkg::ROB_DONE;
	assign commit_tag = head;
	assign commit_rd = dest[head];
	assign commit_data = value[head];

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			for (int k = 0; k < ooo_pkg::ROB_DEPTH; k++)
				state[k] <= ooo_pkg::ROB_FREE;
		end else begin
			if (alloc) begin
				state[tail] <= ooo_pkg::ROB_WAIT;
				tail <= tail + 1'b1;
			end
			if (cdb_valid)
				state[cdb_tag] <= ooo_pkg::ROB_DONE;
			if (commit_valid) begin
				state[head] <= ooo_pkg::ROB_FREE;
				head <= head + 1'b1;
			end
			if (alloc && !commit_valid)
				count <= count + 1'b1;
			else if (commit_valid && !alloc)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (alloc)
			dest[tail] <= alloc_rd;
		if (cdb_valid)
			value[cdb_tag] <= cdb_data;
	end

	// results only for allocated entries
	assert property (@(posedge clk) disable iff (rst)
		cdb_valid |-> state[cdb_tag] != ooo_pkg::ROB_FREE);

	assert property (@(posedge clk) disable iff (rst)
		commit_valid |-> count != '0);

endmodule

// ==== logic/alu_station.sv ====
`timescale 1ns/100ps

module alu_station (
	input logic clk,
	input logic rst,
	input logic dispatch,
	input isa_pkg::opcode_t dispatch_op,
	input logic [ooo_pkg::TAG_BITS-1:0] dispatch_tag,
	input logic src_ready [2],
	input logic [isa_pkg::XLEN-1:0] src_value [2],
	input logic [ooo_pkg::TAG_BITS-1:0] src_tag [2],
	output logic alu_full,
	input logic cdb_valid,
	input logic [ooo_pkg::TAG_BITS-1:0] cdb_tag,
	input logic [isa_pkg::XLEN-1:0] cdb_data,
	output logic req,
	output logic [ooo_pkg::TAG_BITS-1:0] req_tag,
	output logic [isa_pkg::XLEN-1:0] req_value,
	input logic grant
);
	logic [ooo_pkg::STATION_SLOTS-1:0] slot_valid;
	logic [ooo_pkg::STATION_SLOTS-1:0] valid_n;
	isa_pkg::opcode_t slot_op [ooo_pkg::STATION_SLOTS];
	logic [ooo_pkg::TAG_BITS-1:0] slot_tag [ooo_pkg::STATION_SLOTS];
	logic [1:0] slot_rdy [ooo_pkg::STATION_SLOTS];
	logic [isa_pkg::XLEN-1:0] slot_val [ooo_pkg::STATION_SLOTS][2];
	logic [ooo_pkg::TAG_BITS-1:0] slot_stag [ooo_pkg::STATION_SLOTS][2];
	logic older;
	logic older_n;
	logic take_slot;
	logic take_idx;
	logic direct;
	logic free;
	logic fire;
	logic insert;
	logic ins_idx;
	isa_pkg::opcode_t sel_op;
	logic [ooo_pkg::TAG_BITS-1:0] sel_tag;
	logic [isa_pkg::XLEN-1:0] sel_a;
	logic [isa_pkg::XLEN-1:0] sel_b;
	logic [isa_pkg::XLEN-1:0] result;

	// oldest ready slot first
	always_comb begin
		take_slot = 1'b0;
		take_idx = older;
		if (slot_valid[older] && &slot_rdy[older]) begin
			take_slot = 1'b1;
		end else if (slot_valid[~older] && &slot_rdy[~older]) begin
			take_slot = 1'b1;
			take_idx = ~older;
		end
	end

	// result register stalls until granted
	assign free = !req || grant;
	// ready dispatch skips the slots
	assign direct = dispatch && src_ready[0] && src_ready[1] && !take_slot;
	assign fire = free && (take_slot || direct);
	assign insert = dispatch && !(free && direct);
	assign ins_idx = slot_valid[0];
	assign alu_full = &slot_valid;

	always_comb begin
		if (take_slot) begin
			sel_op = slot_op[take_idx];
			sel_tag = slot_tag[take_idx];
			sel_a = slot_val[take_idx][0];
			sel_b = slot_val[take_idx][1];
		end else begin
			sel_op = dispatch_op;
			sel_tag = dispatch_tag;
			sel_a = src_value[0];
			sel_b = src_value[1];
		end
		case (sel_op)
			isa_pkg::OP_ADD: result = sel_a + sel_b;
			isa_pkg::OP_SUB: result = sel_a - sel_b;
			default: result = sel_a;
		endcase
	end

	always_comb begin
		valid_n = slot_valid;
		older_n = older;
		if (fire && take_slot) begin
			valid_n[take_idx] = 1'b0;
			if (take_idx == older)
				older_n = ~older;
		end
		if (insert) begin
			valid_n[ins_idx] = 1'b1;
			if (!valid_n[~ins_idx])
				older_n = ins_idx;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_valid <= '0;
			older <= 1'b0;
			req <= 1'b0;
		end else begin
			slot_valid <= valid_n;
			older <= older_n;
			if (free)
				req <= fire;
		end
	end

	always_ff @(posedge clk) begin
		// operand capture from the result bus
		for (int i = 0; i < ooo_pkg::STATION_SLOTS; i++) begin
			for (int j = 0; j < 2; j++) begin
				if (cdb_valid && !slot_rdy[i][j] && cdb_tag == slot_stag[i][j]) begin
					slot_rdy[i][j] <= 1'b1;
					slot_val[i][j] <= cdb_data;
				end
			end
		end
		if (insert) begin
			slot_op[ins_idx] <= dispatch_op;
			slot_tag[ins_idx] <= dispatch_tag;
			for (int j = 0; j < 2; j++) begin
				slot_rdy[ins_idx][j] <= src_ready[j];
				slot_val[ins_idx][j] <= src_value[j];
				slot_stag[ins_idx][j] <= src_tag[j];
			end
		end
		if (fire) begin
			req_tag <= sel_tag;
			req_value <= result;
		end
	end

endmodule

// ==== logic/mul_unit.sv ====
`timescale 1ns/100ps

module mul_unit (
	input logic clk,
	input logic rst,
	input logic dispatch,
	input isa_pkg::opcode_t dispatch_op,
	input logic [ooo_pkg::TAG_BITS-1:0] dispatch_tag,
	input logic src_ready [2],
	input logic [isa_pkg::XLEN-1:0] src_value [2],
	input logic [ooo_pkg::TAG_BITS-1:0] src_tag [2],
	output logic mul_full,
	input logic cdb_valid,
	input logic [ooo_pkg::TAG_BITS-1:0] cdb_tag,
	input logic [isa_pkg::XLEN-1:0] cdb_data,
	output logic req,
	output logic [ooo_pkg::TAG_BITS-1:0] req_tag,
	output logic [isa_pkg::XLEN-1:0] req_value
);
	localparam int LAST = ooo_pkg::MUL_LATENCY - 1;

	logic [ooo_pkg::STATION_SLOTS-1:0] slot_valid;
	logic [ooo_pkg::STATION_SLOTS-1:0] valid_n;
	logic [ooo_pkg::TAG_BITS-1:0] slot_tag [ooo_pkg::STATION_SLOTS];
	logic [1:0] slot_rdy [ooo_pkg::STATION_SLOTS];
	logic [isa_pkg::XLEN-1:0] slot_val [ooo_pkg::STATION_SLOTS][2];
	logic [ooo_pkg::TAG_BITS-1:0] slot_stag [ooo_pkg::STATION_SLOTS][2];
	logic older;
	logic older_n;
	logic take_slot;
	logic take_idx;
	logic direct;
	logic insert;
	logic ins_idx;
	logic [ooo_pkg::TAG_BITS-1:0] sel_tag;
	logic [isa_pkg::XLEN-1:0] product;
	logic [ooo_pkg::MUL_LATENCY-1:0] pipe_valid;
	logic [ooo_pkg::TAG_BITS-1:0] pipe_tag [ooo_pkg::MUL_LATENCY];
	logic [isa_pkg::XLEN-1:0] pipe_value [ooo_pkg::MUL_LATENCY];

	always_comb begin
		take_slot = 1'b0;
		take_idx = older;
		if (slot_valid[older] && &slot_rdy[older]) begin
			take_slot = 1'b1;
		end else if (slot_valid[~older] && &slot_rdy[~older]) begin
			take_slot = 1'b1;
			take_idx = ~older;
		end
	end

	// pipeline never stalls, so a ready operand pair always enters
	assign direct = dispatch && src_ready[0] && src_ready[1] && !take_slot;
	assign insert = dispatch && !direct;
	assign ins_idx = slot_valid[0];
	assign mul_full = &slot_valid;
	assign sel_tag = take_slot ? slot_tag[take_idx] : dispatch_tag;
	// low half of the product
	assign product = take_slot ? slot_val[take_idx][0] * slot_val[take_idx][1]
		: src_value[0] * src_value[1];

	always_comb begin
		valid_n = slot_valid;
		older_n = older;
		if (take_slot) begin
			valid_n[take_idx] = 1'b0;
			if (take_idx == older)
				older_n = ~older;
		end
		if (insert) begin
			valid_n[ins_idx] = 1'b1;
			if (!valid_n[~ins_idx])
				older_n = ins_idx;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_valid <= '0;
			older <= 1'b0;
			pipe_valid <= '0;
		end else begin
			slot_valid <= valid_n;
			older <= older_n;
			pipe_valid <= {pipe_valid[LAST-1:0], take_slot || direct};
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < ooo_pkg::STATION_SLOTS; i++) begin
			for (int j = 0; j < 2; j++) begin
				if (cdb_valid && !slot_rdy[i][j] && cdb_tag == slot_stag[i][j]) begin
					slot_rdy[i][j] <= 1'b1;
					slot_val[i][j] <= cdb_data;
				end
			end
		end
		if (insert) begin
			slot_tag[ins_idx] <= dispatch_tag;
			for (int j = 0; j < 2; j++) begin
				slot_rdy[ins_idx][j] <= src_ready[j];
				slot_val[ins_idx][j] <= src_value[j];
				slot_stag[ins_idx][j] <= src_tag[j];
			end
		end
		pipe_tag[0] <= sel_tag;
		pipe_value[0] <= product;
		for (int k = 1; k < ooo_pkg::MUL_LATENCY; k++) begin
			pipe_tag[k] <= pipe_tag[k-1];
			pipe_value[k] <= pipe_value[k-1];
		end
	end

	assign req = pipe_valid[LAST];
	assign req_tag = pipe_tag[LAST];
	assign req_value = pipe_value[LAST];

	// issue decode routes only multiplies here
	assert property (@(posedge clk) disable iff (rst)
		dispatch |-> dispatch_op == isa_pkg::OP_MUL);

endmodule

// ==== logic/result_bus.sv ====
`timescale 1ns/100ps

module result_bus (
	input logic clk,
	input logic rst,
	input logic alu_req,
	input logic [ooo_pkg::TAG_BITS-1:0] alu_tag,
	input logic [isa_pkg::XLEN-1:0] alu_value,
	input logic mul_req,
	input logic [ooo_pkg::TAG_BITS-1:0] mul_tag,
	input logic [isa_pkg::XLEN-1:0] mul_value,
	output logic alu_grant,
	output logic cdb_valid,
	output logic [ooo_pkg::TAG_BITS-1:0] cdb_tag,
	output logic [isa_pkg::XLEN-1:0] cdb_data
);
	// multiplier cannot hold its result
	assign alu_grant = alu_req && !mul_req;

	always_ff @(posedge clk) begin
		if (rst)
			cdb_valid <= 1'b0;
		else
			cdb_valid <= alu_req || mul_req;
	end

	always_ff @(posedge clk) begin
		if (mul_req) begin
			cdb_tag <= mul_tag;
			cdb_data <= mul_value;
		end else begin
			cdb_tag <= alu_tag;
			cdb_data <= alu_value;
		end
	end

	assert property (@(posedge clk) disable iff (rst) cdb_valid |-> !$isunknown(cdb_tag));

endmodule

// ==== logic/ooo_core.sv ====
`timescale 1ns/100ps

module ooo_core (
	input logic clk,
	input logic rst,
	input logic insn_valid,
	input isa_pkg::opcode_t insn_op,
	input logic [isa_pkg::REG_BITS-1:0] insn_rd,
	input logic [isa_pkg::REG_BITS-1:0] insn_rs1,
	input logic [isa_pkg::REG_BITS-1:0] insn_rs2,
	input logic [isa_pkg::IMM_BITS-1:0] insn_imm,
	output logic credit,
	output logic commit_valid,
	output logic [isa_pkg::REG_BITS-1:0] commit_rd,
	output logic [isa_pkg::XLEN-1:0] commit_data
);
	//////////////////////////////
	// wires
	//////////////////////////////

	logic [isa_pkg::REG_BITS-1:0] read_idx [2];
	logic reg_pending [2];
	logic [ooo_pkg::TAG_BITS-1:0] reg_tag [2];
	logic [isa_pkg::XLEN-1:0] reg_value [2];
	logic rob_full;
	logic [ooo_pkg::TAG_BITS-1:0] rob_tail_tag;
	logic [ooo_pkg::TAG_BITS-1:0] rob_read_tag [2];
	logic rob_ready [2];
	logic [isa_pkg::XLEN-1:0] rob_value [2];
	logic cdb_valid;
	logic [ooo_pkg::TAG_BITS-1:0] cdb_tag;
	logic [isa_pkg::XLEN-1:0] cdb_data;
	logic alu_full;
	logic mul_full;
	logic alu_dispatch;
	logic mul_dispatch;
	logic dispatch;
	isa_pkg::opcode_t dispatch_op;
	logic [ooo_pkg::TAG_BITS-1:0] dispatch_tag;
	logic [isa_pkg::REG_BITS-1:0] dispatch_rd;
	logic src_ready [2];
	logic [isa_pkg::XLEN-1:0] src_value [2];
	logic [ooo_pkg::TAG_BITS-1:0] src_tag [2];
	logic alu_req;
	logic alu_grant;
	logic [ooo_pkg::TAG_BITS-1:0] alu_tag;
	logic [isa_pkg::XLEN-1:0] alu_value;
	logic mul_req;
	logic [ooo_pkg::TAG_BITS-1:0] mul_tag;
	logic [isa_pkg::XLEN-1:0] mul_value;
	logic [ooo_pkg::TAG_BITS-1:0] commit_tag;

	// either station takes a reorder buffer entry
	assign dispatch = alu_dispatch || mul_dispatch;

	//////////////////////////////
	// units
	//////////////////////////////

	issue_stage issue_stage (
		.clk, .rst,
		.insn_valid, .insn_op, .insn_rd, .insn_rs1, .insn_rs2, .insn_imm,
		.credit, .read_idx,
		.reg_pending, .reg_tag, .reg_value,
		.rob_full, .rob_tail_tag, .rob_ready, .rob_value, .rob_read_tag,
		.cdb_valid, .cdb_tag, .cdb_data,
		.alu_full, .mul_full, .alu_dispatch, .mul_dispatch,
		.dispatch_op, .dispatch_tag, .dispatch_rd,
		.src_ready, .src_value, .src_tag
	);

	register_file register_file (
		.clk, .rst,
		.read_idx, .reg_pending, .reg_tag, .reg_value,
		.rename(dispatch), .rename_rd(dispatch_rd), .rename_tag(dispatch_tag),
		.commit(commit_valid), .commit_rd, .commit_tag, .commit_data
	);

	reorder_buffer reorder_buffer (
		.clk, .rst,
		.alloc(dispatch), .alloc_rd(dispatch_rd),
		.rob_full, .rob_tail_tag, .rob_read_tag, .rob_ready, .rob_value,
		.cdb_valid, .cdb_tag, .cdb_data,
		.commit_valid, .commit_rd, .commit_tag, .commit_data
	);

	alu_station alu_station (
		.clk, .rst,
		.dispatch(alu_dispatch), .dispatch_op, .dispatch_tag,
		.src_ready, .src_value, .src_tag, .alu_full,
		.cdb_valid, .cdb_tag, .cdb_data,
		.req(alu_req), .req_tag(alu_tag), .req_value(alu_value), .grant(alu_grant)
	);

	mul_unit mul_unit (
		.clk, .rst,
		.dispatch(mul_dispatch), .dispatch_op, .dispatch_tag,
		.src_ready, .src_value, .src_tag, .mul_full,
		.cdb_valid, .cdb_tag, .cdb_data,
		.req(mul_req), .req_tag(mul_tag), .req_value(mul_value)
	);

	result_bus result_bus (
		.clk, .rst,
		.alu_req, .alu_tag, .alu_value,
		.mul_req, .mul_tag, .mul_value,
		.alu_grant, .cdb_valid, .cdb_tag, .cdb_data
	);

endmodule

// ==== test/ooo_core_tb.sv ====
`timescale 1ns/100ps

module ooo_core_tb;

	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int RESET_CYCLES = 4;
	// instructions sent by all tests together
	localparam int INSN_TOTAL = 87;
	localparam int CYCLES_PER_INSN = 200;
	localparam int DRAIN_LIMIT = 1000;

	logic clk;
	logic rst;
	logic insn_valid;
	isa_pkg::opcode_t insn_op;
	logic [isa_pkg::REG_BITS-1:0] insn_rd;
	logic [isa_pkg::REG_BITS-1:0] insn_rs1;
	logic [isa_pkg::REG_BITS-1:0] insn_rs2;
	logic [isa_pkg::IMM_BITS-1:0] insn_imm;
	logic credit;
	logic commit_valid;
	logic [isa_pkg::REG_BITS-1:0] commit_rd;
	logic [isa_pkg::XLEN-1:0] commit_data;

	// reference model state
	logic [isa_pkg::XLEN-1:0] model_regs [isa_pkg::REG_COUNT];
	logic [isa_pkg::REG_BITS-1:0] exp_rd [$];
	logic [isa_pkg::XLEN-1:0] exp_data [$];
	int credits;
	int sent_count;
	logic [31:0] lcg_state;

	ooo_core dut (
		.clk, .rst,
		.insn_valid, .insn_op, .insn_rd, .insn_rs1, .insn_rs2, .insn_imm,
		.credit, .commit_valid, .commit_rd, .commit_data
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
			stop_with_failure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h",
				name, got, expected));
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// applies one instruction to the model in program order
	task automatic model_apply(input isa_pkg::opcode_t op,
		input logic [isa_pkg::REG_BITS-1:0] rd, input logic [isa_pkg::REG_BITS-1:0] rs1,
		input logic [isa_pkg::REG_BITS-1:0] rs2, input logic [isa_pkg::IMM_BITS-1:0] imm);
		logic [isa_pkg::XLEN-1:0] a;
		logic [isa_pkg::XLEN-1:0] b;
		logic [2*isa_pkg::XLEN-1:0] wide;
		logic [isa_pkg::XLEN-1:0] value;
		a = model_regs[rs1];
		b = model_regs[rs2];
		case (op)
			isa_pkg::OP_ADD: value = a + b;
			isa_pkg::OP_SUB: value = a - b;
			isa_pkg::OP_MOVI: value = {{(isa_pkg::XLEN - isa_pkg::IMM_BITS){1'b0}}, imm};
			default: begin
				wide = a * b;
				value = wide[isa_pkg::XLEN-1:0];
			end
		endcase
		model_regs[rd] = value;
		exp_rd.push_back(rd);
		exp_data.push_back(value);
	endtask

	// called at the drive point, returns one cycle later at the drive point
	task automatic send_insn(input isa_pkg::opcode_t op,
		input logic [isa_pkg::REG_BITS-1:0] rd, input logic [isa_pkg::REG_BITS-1:0] rs1,
		input logic [isa_pkg::REG_BITS-1:0] rs2, input logic [isa_pkg::IMM_BITS-1:0] imm);
		while (credits == 0) begin
			insn_valid = 1'b0;
			@(posedge clk);
			#DRIVE_DELAY;
		end
		insn_valid = 1'b1;
		insn_op = op;
		insn_rd = rd;
		insn_rs1 = rs1;
		insn_rs2 = rs2;
		insn_imm = imm;
		credits--;
		sent_count++;
		model_apply(op, rd, rs1, rs2, imm);
		@(posedge clk);
		#DRIVE_DELAY;
		insn_valid = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		insn_valid = 1'b0;
		repeat (n) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
	endtask

	task automatic wait_drain;
		int waited;
		waited = 0;
		while (exp_rd.size() != 0 || credits != ooo_pkg::FIFO_DEPTH) begin
			if (waited == DRAIN_LIMIT)
				stop_with_failure($sformatf(
					"core did not drain: %0d commits missing, %0d credits held",
					exp_rd.size(), ooo_pkg::FIFO_DEPTH - credits));
			@(posedge clk);
			#DRIVE_DELAY;
			waited++;
		end
	endtask

	//////////////////////////////
	// monitor
	//////////////////////////////

	always @(negedge clk) begin
		if (!rst) begin
			if (credit) begin
				credits++;
				if (credits > ooo_pkg::FIFO_DEPTH)
					stop_with_failure("core returned more credits than it was given");
			end
			if (commit_valid) begin
				if (exp_rd.size() == 0) begin
					stop_with_failure("commit arrived with no instruction outstanding");
				end else begin
					check_value("commit_rd", commit_rd, exp_rd.pop_front());
					check_value("commit_data", commit_data, exp_data.pop_front());
				end
			end
		end
	end

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic test_idle_then_movi;
		repeat (20) begin
			check_value("commit_valid", commit_valid, 0);
			check_value("credit", credit, 0);
			@(posedge clk);
			#DRIVE_DELAY;
		end
		send_insn(isa_pkg::OP_MOVI, 3'd1, 3'd0, 3'd0, 8'h5a);
		wait_drain();
	endtask

	task automatic test_independent_alu;
		send_insn(isa_pkg::OP_MOVI, 3'd2, 3'd0, 3'd0, 8'h03);
		wait_drain();
		// each reads only committed registers
		send_insn(isa_pkg::OP_SUB, 3'd4, 3'd2, 3'd1, 8'h00);
		send_insn(isa_pkg::OP_ADD, 3'd5, 3'd1, 3'd1, 8'h00);
		send_insn(isa_pkg::OP_SUB, 3'd6, 3'd0, 3'd2, 8'h00);
		send_insn(isa_pkg::OP_MOVI, 3'd7, 3'd0, 3'd0, 8'hc3);
		send_insn(isa_pkg::OP_ADD, 3'd0, 3'd2, 3'd2, 8'h00);
		wait_drain();
		// two negative values wrap on add
		send_insn(isa_pkg::OP_ADD, 3'd3, 3'd4, 3'd6, 8'h00);
		wait_drain();
	endtask

	task automatic test_dependent_chain;
		send_insn(isa_pkg::OP_MOVI, 3'd1, 3'd0, 3'd0, 8'h11);
		send_insn(isa_pkg::OP_ADD, 3'd2, 3'd1, 3'd1, 8'h00);
		send_insn(isa_pkg::OP_ADD, 3'd3, 3'd2, 3'd1, 8'h00);
		send_insn(isa_pkg::OP_SUB, 3'd4, 3'd3, 3'd2, 8'h00);
		send_insn(isa_pkg::OP_ADD, 3'd4, 3'd4, 3'd4, 8'h00);
		send_insn(isa_pkg::OP_ADD, 3'd5, 3'd4, 3'd3, 8'h00);
		// multiply at the head keeps the next result waiting in the reorder buffer
		send_insn(isa_pkg::OP_MUL, 3'd6, 3'd5, 3'd5, 8'h00);
		send_insn(isa_pkg::OP_ADD, 3'd1, 3'd2, 3'd2, 8'h00);
		idle_cycles(3);
		send_insn(isa_pkg::OP_ADD, 3'd7, 3'd1, 3'd1, 8'h00);
		wait_drain();
	endtask

	task automatic test_mul_then_alu;
		send_insn(isa_pkg::OP_MUL, 3'd1, 3'd2, 3'd3, 8'h00);
		send_insn(isa_pkg::OP_MOVI, 3'd4, 3'd0, 3'd0, 8'h7e);
		send_insn(isa_pkg::OP_SUB, 3'd6, 3'd2, 3'd3, 8'h00);
		send_insn(isa_pkg::OP_ADD, 3'd7, 3'd0, 3'd2, 8'h00);
		send_insn(isa_pkg::OP_MUL, 3'd0, 3'd6, 3'd6, 8'h00);
		wait_drain();
	endtask

	task automatic test_overwrite;
		send_insn(isa_pkg::OP_MOVI, 3'd3, 3'd0, 3'd0, 8'h01);
		send_insn(isa_pkg::OP_MOVI, 3'd3, 3'd0, 3'd0, 8'h02);
		send_insn(isa_pkg::OP_ADD, 3'd3, 3'd3, 3'd3, 8'h00);
		send_insn(isa_pkg::OP_MOVI, 3'd3, 3'd0, 3'd0, 8'h09);
		send_insn(isa_pkg::OP_ADD, 3'd2, 3'd3, 3'd3, 8'h00);
		wait_drain();
	endtask

	task automatic test_random_stream;
		logic [31:0] bits;
		for (int n = 0; n < 60; n++) begin
			lcg_state = lcg_next(lcg_state);
			bits = lcg_state;
			send_insn(isa_pkg::opcode_t'(bits[31:30]), bits[29:27], bits[26:24],
				bits[23:21], bits[20:13]);
		end
		wait_drain();
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		rst = 1'b1;
		insn_valid = 1'b0;
		insn_op = isa_pkg::OP_ADD;
		insn_rd = '0;
		insn_rs1 = '0;
		insn_rs2 = '0;
		insn_imm = '0;
		credits = ooo_pkg::FIFO_DEPTH;
		sent_count = 0;
		lcg_state = 32'h1613_b26d;
		for (int k = 0; k < isa_pkg::REG_COUNT; k++)
			model_regs[k] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		test_idle_then_movi();
		test_independent_alu();
		test_dependent_chain();
		test_mul_then_alu();
		test_overwrite();
		test_random_stream();
		if (sent_count != INSN_TOTAL) begin
			stop_with_failure($sformatf("sent %0d instructions instead of %0d",
				sent_count, INSN_TOTAL));
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

	// watchdog
	initial begin
		#((RESET_CYCLES + 20 + INSN_TOTAL * CYCLES_PER_INSN) * CLK_PERIOD);
		stop_with_failure("watchdog expired before the tests finished");
	end

endmodule

// ==== verilog.f ====
logic/isa_pkg.sv
logic/ooo_pkg.sv
logic/issue_stage.sv
logic/register_file.sv
logic/reorder_buffer.sv
logic/alu_station.sv
logic/mul_unit.sv
logic/result_bus.sv
logic/ooo_core.sv
test/ooo_core_tb.sv
